// ==== pet_kbd_pkg.sv ====
`default_nettype none

package pet_kbd_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // address map
    // ~~~~~~~~~~~~~~~~~~~~

    // spi address of cached matrix row 0
    localparam logic [16:0] kbd_base_addr = 17'h0_E800;

    // ten rows, as on the pet keyboard
    localparam int unsigned kbd_rows = 10;

    // last spi address inside the matrix window
    localparam logic [16:0] kbd_last_addr = kbd_base_addr + 17'(kbd_rows - 1);

    // row index width
    // port a carries a full nibble, so 10..15 are reachable
    localparam int unsigned kbd_row_w = 4;

    // cpu address of pia1, four byte-wide registers from here
    localparam logic [15:0] pia1_base_addr = 16'hE810;

    // no key pressed, columns are active low
    localparam logic [7:0] key_released = 8'hFF;

    // ~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~

    // pia1 register select, in rs1:rs0 order
    typedef enum logic [1:0] {
        port_a = 2'd0,
        cr_a   = 2'd1,
        port_b = 2'd2,
        cr_b   = 2'd3
    } pia_reg_e;

    // host write beat, already assembled by the spi shifter
    typedef struct packed {
        logic [16:0] addr;
        logic [7:0]  data;
    } spi_wr_t;

    // cpu bus access, qualified by req_valid outside the struct
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd;
        logic        wr;
    } cpu_req_t;

    // decoded pia1 access, qualified by the hit strobe
    typedef struct packed {
        pia_reg_e   sel;
        logic [7:0] data;
        logic       rd;
        logic       wr;
    } pia_access_t;

    // read response back to the cpu
    // from_kbd tags reads answered by the cached matrix
    typedef struct packed {
        logic [7:0] data;
        logic       from_kbd;
    } cpu_rsp_t;

endpackage

`default_nettype wire

// ==== spi_write_port.sv ====
`default_nettype none

module spi_write_port (
    input  logic                              clk_bus_i,
    input  logic                              reset_i,

    // host write beats
    input  pet_kbd_pkg::spi_wr_t              spi_wr_i,
    input  logic                              spi_valid_i,
    output logic                              spi_ready_o,

    // matrix write strobe towards the keyboard block
    output logic                              mtx_wr_o,
    output logic [pet_kbd_pkg::kbd_row_w-1:0] mtx_row_o,
    output logic [7:0]                        mtx_data_o
);
    import pet_kbd_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // one-entry buffer
    // ~~~~~~~~~~~~~~~~~~~~

    logic    buf_valid;
    spi_wr_t buf_beat;
    logic    accept;
    logic    drain;
    logic    in_window;

    // keyboard takes every strobe, so a held beat always leaves this cycle
    assign drain = buf_valid;

    // room when empty, or when the held beat goes out on this edge
    assign spi_ready_o = !buf_valid || drain;

    assign accept = spi_valid_i && spi_ready_o;

    always_ff @(posedge clk_bus_i or posedge reset_i) begin
        if (reset_i) begin
            buf_valid <= 1'b0;
        end else if (accept) begin
            // new beat replaces the one draining now
            buf_valid <= 1'b1;
        end else if (drain) begin
            buf_valid <= 1'b0;
        end
    end

    // beat payload
    always_ff @(posedge clk_bus_i) begin
        if (accept) begin
            buf_beat <= spi_wr_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // matrix window filter
    // ~~~~~~~~~~~~~~~~~~~~

    // E800..E809 only, anything else is accepted then dropped here
    assign in_window = (buf_beat.addr >= kbd_base_addr) &&
                       (buf_beat.addr <= kbd_last_addr);

    assign mtx_wr_o = buf_valid && in_window;

    // window base sits on a 16-byte boundary
    // so the low nibble of the address is the row index
    assign mtx_row_o = buf_beat.addr[kbd_row_w-1:0];

    assign mtx_data_o = buf_beat.data;

endmodule

`default_nettype wire

// ==== pia_bus_interface.sv ====
`default_nettype none

module pia_bus_interface (
    input  logic                     clk_bus_i,
    input  logic                     reset_i,

    // cpu side
    input  pet_kbd_pkg::cpu_req_t    cpu_req_i,
    input  logic                     req_valid_i,

    // decoded access to pia1 and the keyboard snooper
    output pet_kbd_pkg::pia_access_t pia_acc_o,
    output logic                     pia_hit_o,

    // registered read sources
    input  logic [7:0]               kbd_data_i,
    input  logic                     kbd_hit_i,
    input  logic [7:0]               pia_data_i,

    // read response, one cycle after the access
    output pet_kbd_pkg::cpu_rsp_t    cpu_rsp_o,
    output logic                     rsp_valid_o
);
    import pet_kbd_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // address decode
    // ~~~~~~~~~~~~~~~~~~~~

    logic in_pia1;
    logic rd_pending;

    // pia1 spans E810..E813
    // base is 4-aligned so the upper 14 bits pick the chip
    assign in_pia1 = (cpu_req_i.addr[15:2] == pia1_base_addr[15:2]);

    assign pia_hit_o = req_valid_i && in_pia1;

    // rs1:rs0 come straight from the two low address bits
    always_comb begin
        pia_acc_o.sel  = pia_reg_e'(cpu_req_i.addr[1:0]);
        pia_acc_o.data = cpu_req_i.data;
        pia_acc_o.rd   = cpu_req_i.rd;
        pia_acc_o.wr   = cpu_req_i.wr;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read response
    // ~~~~~~~~~~~~~~~~~~~~

    // read qualifier delayed to line up with the registered sources
    always_ff @(posedge clk_bus_i or posedge reset_i) begin
        if (reset_i) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= pia_hit_o && cpu_req_i.rd;
        end
    end

    assign rsp_valid_o = rd_pending;

    // keyboard wins only when its cached row has a key down
    // otherwise the physical keyboard answers through pia1
    always_comb begin
        if (kbd_hit_i) begin
            cpu_rsp_o.data = kbd_data_i;
        end else begin
            cpu_rsp_o.data = pia_data_i;
        end
        cpu_rsp_o.from_kbd = kbd_hit_i;
    end

endmodule

`default_nettype wire

// ==== keyboard.sv ====
`default_nettype none

module keyboard (
    input  logic                              clk_bus_i,
    input  logic                              reset_i,

    // matrix writes from the spi path
    input  logic                              mtx_wr_i,
    input  logic [pet_kbd_pkg::kbd_row_w-1:0] mtx_row_i,
    input  logic [7:0]                        mtx_data_i,

    // snooped pia1 access
    input  pet_kbd_pkg::pia_access_t          pia_acc_i,
    input  logic                              pia_hit_i,

    // port b intercept
    output logic [7:0]                        kbd_data_o,
    output logic                              kbd_hit_o
);
    import pet_kbd_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // cached key matrix
    // ~~~~~~~~~~~~~~~~~~~~

    // one byte per row, a clear bit is a pressed key
    logic [7:0]           mtx_q [kbd_rows];
    logic [kbd_row_w-1:0] row_q;
    logic [7:0]           row_val;
    logic                 wr_port_a;
    logic                 rd_any;
    logic                 rd_port_b;

    always_ff @(posedge clk_bus_i or posedge reset_i) begin
        if (reset_i) begin
            // every key up
            for (int i = 0; i < kbd_rows; i++) begin
                mtx_q[i] <= key_released;
            end
        end else if (mtx_wr_i && (mtx_row_i < kbd_rows)) begin
            mtx_q[mtx_row_i] <= mtx_data_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // row select snoop
    // ~~~~~~~~~~~~~~~~~~~~

    // the pet scans by writing the row number to port a
    assign wr_port_a = pia_hit_i && pia_acc_i.wr && (pia_acc_i.sel == port_a);

    always_ff @(posedge clk_bus_i or posedge reset_i) begin
        if (reset_i) begin
            row_q <= '0;
        end else if (wr_port_a) begin
            row_q <= pia_acc_i.data[kbd_row_w-1:0];
        end
    end

    // rows 10..15 have no cached entry and read as all keys up
    always_comb begin
        if (row_q < kbd_rows) begin
            row_val = mtx_q[row_q];
        end else begin
            row_val = key_released;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // port b intercept
    // ~~~~~~~~~~~~~~~~~~~~

    assign rd_any    = pia_hit_i && pia_acc_i.rd;
    assign rd_port_b = rd_any && (pia_acc_i.sel == port_b);

    // hit is refreshed on every pia1 read
    // a read of another register must not inherit an old port b hit
    always_ff @(posedge clk_bus_i or posedge reset_i) begin
        if (reset_i) begin
            kbd_hit_o <= 1'b0;
        end else if (rd_any) begin
            kbd_hit_o <= rd_port_b && (row_val != key_released);
        end
    end

    // row value captured on the same edge as the hit flag
    always_ff @(posedge clk_bus_i or posedge reset_i) begin
        if (reset_i) begin
            kbd_data_o <= key_released;
        end else if (rd_port_b) begin
            kbd_data_o <= row_val;
        end
    end

endmodule

`default_nettype wire

// ==== pia1_lite.sv ====
`default_nettype none

module pia1_lite (
    input  logic                     clk_bus_i,
    input  logic                     reset_i,

    // decoded pia1 access
    input  pet_kbd_pkg::pia_access_t pia_acc_i,
    input  logic                     pia_hit_i,

    // physical keyboard
    input  logic [7:0]               col_pins_i,
    output logic [3:0]               row_pins_o,

    // registered read data
    output logic [7:0]               pia_data_o
);
    import pet_kbd_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // registers
    // ~~~~~~~~~~~~~~~~~~~~

    logic [7:0] ora_q;
    logic [7:0] cra_q;
    logic [7:0] crb_q;
    logic [7:0] pb_in_q;
    logic       wr_en;
    logic       rd_en;

    assign wr_en = pia_hit_i && pia_acc_i.wr;
    assign rd_en = pia_hit_i && pia_acc_i.rd;

    always_ff @(posedge clk_bus_i or posedge reset_i) begin
        if (reset_i) begin
            ora_q <= '0;
            cra_q <= '0;
            crb_q <= '0;
        end else if (wr_en) begin
            case (pia_acc_i.sel)
                port_a:  ora_q <= pia_acc_i.data;
                cr_a:    cra_q <= pia_acc_i.data;
                cr_b:    crb_q <= pia_acc_i.data;
                // port b is input only here
                port_b:  ;
                default: ;
            endcase
        end
    end

    // low nibble of port a drives the row decoder on the board
    assign row_pins_o = ora_q[3:0];

    // ~~~~~~~~~~~~~~~~~~~~
    // port b input
    // ~~~~~~~~~~~~~~~~~~~~

    // column lines are sampled every cycle
    // idle value matches pulled-up, unpressed columns
    always_ff @(posedge clk_bus_i or posedge reset_i) begin
        if (reset_i) begin
            pb_in_q <= key_released;
        end else begin
            pb_in_q <= col_pins_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // readback
    // ~~~~~~~~~~~~~~~~~~~~

    // one cycle of latency, same as the keyboard intercept
    always_ff @(posedge clk_bus_i or posedge reset_i) begin
        if (reset_i) begin
            pia_data_o <= key_released;
        end else if (rd_en) begin
            case (pia_acc_i.sel)
                port_a:  pia_data_o <= ora_q;
                cr_a:    pia_data_o <= cra_q;
                port_b:  pia_data_o <= pb_in_q;
                cr_b:    pia_data_o <= crb_q;
                default: pia_data_o <= key_released;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== pet_kbd_top.sv ====
`default_nettype none

module pet_kbd_top (
    input  logic                  clk_bus_i,
    input  logic                  reset_i,

    // host spi write beats
    input  pet_kbd_pkg::spi_wr_t  spi_wr_i,
    input  logic                  spi_valid_i,
    output logic                  spi_ready_o,

    // cpu bus
    input  pet_kbd_pkg::cpu_req_t cpu_req_i,
    input  logic                  req_valid_i,
    output pet_kbd_pkg::cpu_rsp_t cpu_rsp_o,
    output logic                  rsp_valid_o,

    // physical keyboard
    input  logic [7:0]            col_pins_i,
    output logic [3:0]            row_pins_o
);
    import pet_kbd_pkg::*;

    // spi path into the cached matrix
    logic                 mtx_wr;
    logic [kbd_row_w-1:0] mtx_row;
    logic [7:0]           mtx_data;

    // decoded pia1 access, shared by both responders
    pia_access_t          pia_acc;
    logic                 pia_hit;

    // read sources
    logic [7:0]           kbd_data;
    logic                 kbd_hit;
    logic [7:0]           pia_data;

    spi_write_port u_spi_write_port (
        .clk_bus_i   (clk_bus_i),
        .reset_i     (reset_i),
        .spi_wr_i    (spi_wr_i),
        .spi_valid_i (spi_valid_i),
        .spi_ready_o (spi_ready_o),
        .mtx_wr_o    (mtx_wr),
        .mtx_row_o   (mtx_row),
        .mtx_data_o  (mtx_data)
    );

    pia_bus_interface u_pia_bus_interface (
        .clk_bus_i   (clk_bus_i),
        .reset_i     (reset_i),
        .cpu_req_i   (cpu_req_i),
        .req_valid_i (req_valid_i),
        .pia_acc_o   (pia_acc),
        .pia_hit_o   (pia_hit),
        .kbd_data_i  (kbd_data),
        .kbd_hit_i   (kbd_hit),
        .pia_data_i  (pia_data),
        .cpu_rsp_o   (cpu_rsp_o),
        .rsp_valid_o (rsp_valid_o)
    );

    keyboard u_keyboard (
        .clk_bus_i  (clk_bus_i),
        .reset_i    (reset_i),
        .mtx_wr_i   (mtx_wr),
        .mtx_row_i  (mtx_row),
        .mtx_data_i (mtx_data),
        .pia_acc_i  (pia_acc),
        .pia_hit_i  (pia_hit),
        .kbd_data_o (kbd_data),
        .kbd_hit_o  (kbd_hit)
    );

    pia1_lite u_pia1_lite (
        .clk_bus_i  (clk_bus_i),
        .reset_i    (reset_i),
        .pia_acc_i  (pia_acc),
        .pia_hit_i  (pia_hit),
        .col_pins_i (col_pins_i),
        .row_pins_o (row_pins_o),
        .pia_data_o (pia_data)
    );

endmodule

`default_nettype wire

// ==== tb_pet_kbd.sv ====
`default_nettype none

module tb_pet_kbd;
    import pet_kbd_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {op_spi, op_wr, op_rd} op_e;

    // col, vld, rsp and row are filled in by the reference model
    typedef struct packed {
        op_e         op;
        logic [16:0] addr;
        logic [7:0]  data;
        logic [7:0]  col;
        logic        vld;
        cpu_rsp_t    rsp;
        logic [3:0]  row;
    } entry_t;

    localparam logic [16:0] a_pa  = 17'(pia1_base_addr);
    localparam logic [16:0] a_cra = a_pa + 17'd1;
    localparam logic [16:0] a_pb  = a_pa + 17'd2;
    localparam logic [16:0] a_crb = a_pa + 17'd3;

    logic       clk_bus_i;
    logic       reset_i;
    spi_wr_t    spi_wr_i;
    logic       spi_valid_i;
    logic       spi_ready_o;
    cpu_req_t   cpu_req_i;
    logic       req_valid_i;
    cpu_rsp_t   cpu_rsp_o;
    logic       rsp_valid_o;
    logic [7:0] col_pins_i;
    logic [3:0] row_pins_o;

    entry_t     tbl[$];
    int         cycles;
    int         limit;
    // response owed on the next check, from the read driven one cycle earlier
    logic       rsp_due;
    cpu_rsp_t   rsp_exp;
    logic [3:0] row_exp;

    pet_kbd_top u_dut (.*);

    always #20 clk_bus_i = ~clk_bus_i;

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // pia1 occupies four bytes from its base
    function automatic logic in_pia1(input logic [15:0] addr);
        return (addr >= pia1_base_addr) && (addr <= pia1_base_addr + 16'd3);
    endfunction

    task automatic stop_fail();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_rsp(input string name, input cpu_rsp_t exp, input cpu_rsp_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected data=%02h from_kbd=%b got data=%02h from_kbd=%b",
                     $time, name, exp.data, exp.from_kbd, act.data, act.from_kbd);
            stop_fail();
        end
    endtask

    task automatic check_row_pins(input string name, input logic [3:0] exp,
                                  input logic [3:0] act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            stop_fail();
        end
    endtask

    task automatic add_entry(input op_e op, input logic [16:0] addr, input logic [7:0] data);
        entry_t e;
        e = '0;
        e.op = op;
        e.addr = addr;
        e.data = data;
        tbl.push_back(e);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic build_expected();
        entry_t      e;
        logic [7:0]  mtx [kbd_rows];
        logic [3:0]  latch;
        logic [7:0]  ora;
        logic [7:0]  cra;
        logic [7:0]  crb;
        logic [7:0]  val;
        logic [31:0] seed;
        seed = 32'h58d0_851b;
        latch = '0;
        ora = '0;
        cra = '0;
        crb = '0;
        for (int r = 0; r < kbd_rows; r++) begin
            mtx[r] = key_released;
        end
        foreach (tbl[i]) begin
            e = tbl[i];
            seed = xorshift32(seed);
            e.col = seed[7:0];
            e.vld = (e.op == op_rd) && in_pia1(e.addr[15:0]);
            e.rsp = '0;
            if (e.op == op_spi) begin
                // matrix window is E800..E809, whole 17-bit address compared
                if (e.addr >= kbd_base_addr && e.addr <= kbd_base_addr + 17'd9) begin
                    mtx[e.addr - kbd_base_addr] = e.data;
                end
            end else if (e.op == op_wr && in_pia1(e.addr[15:0])) begin
                case (e.addr[1:0])
                    2'd0: begin
                        ora = e.data;
                        latch = e.data[3:0];
                    end
                    2'd1: cra = e.data;
                    2'd3: crb = e.data;
                    default: ;
                endcase
            end else if (e.vld) begin
                case (e.addr[1:0])
                    2'd0: e.rsp = '{data: ora, from_kbd: 1'b0};
                    2'd1: e.rsp = '{data: cra, from_kbd: 1'b0};
                    2'd3: e.rsp = '{data: crb, from_kbd: 1'b0};
                    default: begin
                        // rows past the matrix act as all keys up
                        val = (latch < kbd_rows) ? mtx[latch] : key_released;
                        if (val != key_released) begin
                            e.rsp = '{data: val, from_kbd: 1'b1};
                        end else begin
                            e.rsp = '{data: e.col, from_kbd: 1'b0};
                        end
                    end
                endcase
            end
            e.row = ora[3:0];
            tbl[i] = e;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // drive and check
    // ~~~~~~~~~~~~~~~~~~~~

    // called at the falling edge, outputs settled since the last rising edge
    task automatic check_outputs();
        if (rsp_due && !rsp_valid_o) begin
            $display("no read response one cycle after a PIA1 read at %0t", $time);
            stop_fail();
        end
        if (!rsp_due && rsp_valid_o) begin
            $display("read response without a PIA1 read before it at %0t", $time);
            stop_fail();
        end
        if (rsp_due) begin
            check_rsp("cpu_rsp_o", rsp_exp, cpu_rsp_o);
        end
        check_row_pins("row_pins_o", row_exp, row_pins_o);
        rsp_due = 1'b0;
    endtask

    task automatic apply_entry(input int i);
        entry_t e;
        e = tbl[i];
        @(posedge clk_bus_i);
        // pins lead by one entry since port b samples them a cycle early
        col_pins_i  <= (i + 1 < tbl.size()) ? tbl[i+1].col : e.col;
        cpu_req_i   <= '{addr: e.addr[15:0], data: e.data,
                         rd: (e.op == op_rd), wr: (e.op == op_wr)};
        req_valid_i <= (e.op != op_spi);
        spi_wr_i    <= '{addr: e.addr, data: e.data};
        spi_valid_i <= (e.op == op_spi);
        @(negedge clk_bus_i);
        check_outputs();
        rsp_due = e.vld;
        rsp_exp = e.rsp;
        row_exp = e.row;
        if (e.op == op_spi) begin
            while (!spi_ready_o) begin
                @(negedge clk_bus_i);
                check_outputs();
            end
            @(posedge clk_bus_i);
            spi_valid_i <= 1'b0;
            // beat is buffered, then written to the row one edge later
            repeat (2) begin
                @(negedge clk_bus_i);
                check_outputs();
                @(posedge clk_bus_i);
            end
        end
    endtask

    task automatic fill_table();
        // reset state, no cached key down
        add_entry(op_rd, a_pb, 8'h00);
        add_entry(op_wr, a_pa, 8'h07);
        add_entry(op_rd, a_pb, 8'h00);
        // key down in row 3, then row 2 falls through
        add_entry(op_spi, kbd_base_addr + 17'd3, 8'hEF);
        add_entry(op_wr, a_pa, 8'h03);
        add_entry(op_rd, a_pb, 8'h00);
        add_entry(op_wr, a_pa, 8'h02);
        add_entry(op_rd, a_pb, 8'h00);
        // last row, then beats outside the window
        add_entry(op_spi, kbd_base_addr + 17'd9, 8'h7E);
        add_entry(op_spi, kbd_base_addr + 17'd10, 8'h00);
        add_entry(op_spi, kbd_base_addr - 17'd1, 8'h00);
        add_entry(op_spi, 17'h1_E805, 8'h00);
        add_entry(op_wr, a_pa, 8'h09);
        add_entry(op_rd, a_pb, 8'h00);
        add_entry(op_wr, a_pa, 8'h05);
        add_entry(op_rd, a_pb, 8'h00);
        // rows 10..15
        add_entry(op_wr, a_pa, 8'hAA);
        add_entry(op_rd, a_pb, 8'h00);
        add_entry(op_wr, a_pa, 8'h3F);
        add_entry(op_rd, a_pb, 8'h00);
        // control registers and port a readback
        add_entry(op_wr, a_cra, 8'h3C);
        add_entry(op_wr, a_crb, 8'hA5);
        add_entry(op_rd, a_cra, 8'h00);
        add_entry(op_rd, a_crb, 8'h00);
        add_entry(op_rd, a_pa, 8'h00);
        add_entry(op_rd, 17'h0_E814, 8'h00);
        // back to back reads, upper port a bits ignored by the row latch
        add_entry(op_wr, a_pa, 8'hF3);
        add_entry(op_rd, a_pb, 8'h00);
        add_entry(op_rd, a_pb, 8'h00);
        add_entry(op_rd, a_cra, 8'h00);
        add_entry(op_rd, a_pb, 8'h00);
    endtask

    // run limit
    always @(posedge clk_bus_i) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the run did not finish", limit);
            stop_fail();
        end
    end

    initial begin
        clk_bus_i   = 1'b0;
        reset_i     = 1'b1;
        spi_wr_i    = '0;
        spi_valid_i = 1'b0;
        cpu_req_i   = '0;
        req_valid_i = 1'b0;
        rsp_due     = 1'b0;
        rsp_exp     = '0;
        row_exp     = '0;
        cycles      = 0;
        fill_table();
        build_expected();
        limit = 4 * tbl.size() + 50;
        col_pins_i = tbl[0].col;
        repeat (3) @(posedge clk_bus_i);
        reset_i <= 1'b0;
        foreach (tbl[i]) begin
            apply_entry(i);
        end
        @(posedge clk_bus_i);
        req_valid_i <= 1'b0;
        @(negedge clk_bus_i);
        check_outputs();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
pet_kbd_pkg.sv
spi_write_port.sv
pia_bus_interface.sv
keyboard.sv
pia1_lite.sv
pet_kbd_top.sv
tb_pet_kbd.sv
